/* all.f */
+incdir+include
design/alu_pkg.sv
design/aluDecode.sv
design/aluArith.sv
design/aluLogicShift.sv
design/branchUnit.sv
design/aluWriteback.sv
design/aluTop.sv
bench/aluTop_checker.sv
bench/aluTop_tb.sv

/* Bender.yml */
package:
  name: alu16

sources:
  - include_dirs:
      - include
    files:
      - design/alu_pkg.sv
      - design/aluDecode.sv
      - design/aluArith.sv
      - design/aluLogicShift.sv
      - design/branchUnit.sv
      - design/aluWriteback.sv
      - design/aluTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/aluTop_checker.sv
      - bench/aluTop_tb.sv

/* bench/aluTop_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module aluTop_tb;

	localparam int ResetCycles = 3;
	localparam int ArithOps    = 300;
	localparam int LogicOps    = 200;
	localparam int ShiftOps    = 150;
	localparam int BranchPairs = 250;
	localparam int StreamOps   = 60;
	localparam int CycleLimit  = ResetCycles + ArithOps + LogicOps + ShiftOps
		+ 2 * BranchPairs + StreamOps + 50; // One drain cycle per test plus slack

	// Opcodes outside every pattern of the encoding
	localparam logic [7:0] Undecoded [8] = '{8'h00, 8'h07, 8'h0C, 8'h40,
		8'h70, 8'h85, 8'hA5, 8'hE3};

	// Bench view of an instruction, keeps immediate forms apart
	typedef enum int
	{
		kAdd, kAddi, kAddu, kAddui, kSub, kSubi, kCmp, kCmpi,
		kAnd, kAndi, kOr, kOri, kXor, kXori, kNot, kMov, kMovi, kLui,
		kLsh, kLshi, kAshu, kAshui, kBcond, kJcond, kUndef
	} opKind_e;

	logic            clk;
	logic            rstN;
	logic            opValid;
	logic [7:0]      opcode;
	alu_pkg::word_t  operandA;
	alu_pkg::word_t  operandB;
	alu_pkg::word_t  pc;
	logic            resultValid;
	alu_pkg::word_t  result;
	alu_pkg::flags_t flags;
	logic            taken;

	integer         seed       = 32'hc767;
	int             errors     = 0;
	int             checks     = 0;
	int             tests      = 0;
	int             cycleCount = 0;
	logic           expValid;  // Expected outputs for the last driven cycle
	alu_pkg::word_t expResult;
	logic           expTaken;
	logic [4:0]     mFlags;    // Model flag register

	aluTop u_dut
	(
		.clk         (clk),
		.rstN        (rstN),
		.opValid     (opValid),
		.opcode      (opcode),
		.operandA    (operandA),
		.operandB    (operandB),
		.pc          (pc),
		.resultValid (resultValid),
		.result      (result),
		.flags       (flags),
		.taken       (taken)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("Run stopped after %0d cycles, the tests did not finish", cycleCount);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic int randBelow(input int n);
		randBelow = ($random(seed) & 32'h7fffffff) % n;
	endfunction

	function automatic alu_pkg::word_t randWord();
		randWord = $random(seed);
	endfunction

	function automatic logic [7:0] opcodeOf(input opKind_e kind, input logic [3:0] low);
		case (kind)
			kAdd:    opcodeOf = `OP_ADD;
			kAddi:   opcodeOf = {4'h5, low};
			kAddu:   opcodeOf = `OP_ADDU;
			kAddui:  opcodeOf = {4'h6, low};
			kSub:    opcodeOf = `OP_SUB;
			kSubi:   opcodeOf = {4'h9, low};
			kCmp:    opcodeOf = `OP_CMP;
			kCmpi:   opcodeOf = {4'hB, low};
			kAnd:    opcodeOf = `OP_AND;
			kAndi:   opcodeOf = {4'h1, low};
			kOr:     opcodeOf = `OP_OR;
			kOri:    opcodeOf = {4'h2, low};
			kXor:    opcodeOf = `OP_XOR;
			kXori:   opcodeOf = {4'h3, low};
			kNot:    opcodeOf = `OP_NOT;
			kMov:    opcodeOf = `OP_MOV;
			kMovi:   opcodeOf = {4'hD, low};
			kLui:    opcodeOf = {4'hF, low};
			kLsh:    opcodeOf = `OP_LSH;
			kLshi:   opcodeOf = {7'b1000000, low[0]}; // Bit 0 is the direction
			kAshu:   opcodeOf = `OP_ASHU;
			kAshui:  opcodeOf = {7'b1000001, low[0]};
			kBcond:  opcodeOf = {4'hC, low};
			kJcond:  opcodeOf = `OP_JCOND;
			default: opcodeOf = Undecoded[low[2:0]];
		endcase
	endfunction

	// Condition against the model flags as they stood before the op
	function automatic logic condHolds(input logic [3:0] cond);
		logic c;
		logic f;
		logic l;
		logic z;
		logic n;
		c = mFlags[`FLAG_C];
		f = mFlags[`FLAG_F];
		l = mFlags[`FLAG_L];
		z = mFlags[`FLAG_Z];
		n = mFlags[`FLAG_N];
		case (cond)
			`COND_EQ: condHolds = z;
			`COND_NE: condHolds = !z;
			`COND_GE: condHolds = n | z;
			`COND_CS: condHolds = c;
			`COND_CC: condHolds = !c;
			`COND_HI: condHolds = l;
			`COND_LS: condHolds = !l;
			`COND_LO: condHolds = !(l | z);
			`COND_HS: condHolds = l | z;
			`COND_GT: condHolds = n;
			`COND_LE: condHolds = !n;
			`COND_FS: condHolds = f;
			`COND_FC: condHolds = !f;
			`COND_LT: condHolds = !(n | z);
			`COND_UC: condHolds = 1'b1;
			default:  condHolds = 1'b0; // NJ
		endcase
	endfunction

	task automatic predict(input opKind_e kind, input logic [7:0] opc, input alu_pkg::word_t a,
		input alu_pkg::word_t b, input alu_pkg::word_t p);
		alu_pkg::word_t bb;
		logic [16:0]    wide;
		int             exact;
		int             amount;
		logic           right;
		logic           go;
		case (kind)
			kAddi, kSubi, kCmpi, kBcond:     bb = {{8{b[7]}}, b[7:0]};
			kAddui, kAndi, kOri, kXori, kMovi: bb = {8'h00, b[7:0]};
			kLui:                            bb = {b[7:0], 8'h00};
			default:                         bb = b;
		endcase
		expValid  = 1'b1;
		expResult = a;
		expTaken  = 1'b0;
		case (kind)
			kAdd, kAddi, kAddu, kAddui:
			begin
				wide            = {1'b0, a} + {1'b0, bb};
				expResult       = wide[15:0];
				mFlags[`FLAG_C] = wide[16];
				exact           = int'($signed(a)) + int'($signed(bb));
				if (kind == kAdd || kind == kAddi)
					mFlags[`FLAG_F] = exact > 32767 || exact < -32768; // Unsigned adds keep F
			end
			kSub, kSubi:
			begin
				expResult       = a - bb;
				exact           = int'($signed(a)) - int'($signed(bb));
				mFlags[`FLAG_C] = a < bb; // Borrow
				mFlags[`FLAG_F] = exact > 32767 || exact < -32768;
			end
			kCmp, kCmpi:
			begin
				expResult       = a - bb;
				mFlags[`FLAG_L] = a < bb;
				mFlags[`FLAG_N] = $signed(a) < $signed(bb);
				mFlags[`FLAG_Z] = a == bb;
			end
			kAnd, kAndi, kOr, kOri, kXor, kXori, kNot:
			begin
				if (kind == kAnd || kind == kAndi)
					expResult = a & bb;
				else if (kind == kOr || kind == kOri)
					expResult = a | bb;
				else if (kind == kNot)
					expResult = ~a;
				else
					expResult = a ^ bb;
				mFlags[`FLAG_Z] = expResult == 16'h0000;
			end
			kMovi, kLui: expResult = bb;
			kLsh, kAshu, kLshi, kAshui:
			begin
				if (kind == kLsh || kind == kAshu)
				begin
					right  = b[15]; // Negative count shifts right by its magnitude
					amount = right ? 65536 - int'(b) : int'(b);
				end
				else
				begin
					right  = opc[0];
					amount = int'(b[3:0]);
				end
				if (amount >= 16)
					expResult = (right && a[15] && (kind == kAshu || kind == kAshui)) ? 16'hFFFF : 16'h0000;
				else if (!right)
					expResult = a << amount;
				else if (kind == kAshu || kind == kAshui)
					expResult = $signed(a) >>> amount;
				else
					expResult = a >> amount;
			end
			kBcond, kJcond:
			begin
				go       = condHolds(a[3:0]);
				expTaken = go;
				if (!go)
					expResult = p + 16'd1;
				else if (kind == kBcond)
					expResult = p + bb;
				else
					expResult = b; // Jump target straight from the register
			end
			default: expResult = a; // MOV and undecoded pass A
		endcase
	endtask

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compareOutputs();
		checkValue("resultValid", resultValid, expValid);
		checkValue("result", result, expResult);
		checkValue("flags", flags, mFlags);
		checkValue("taken", taken, expTaken);
	endtask

	// Checks the previous cycle, then drives the next one on the falling edge
	task automatic issue(input logic valid, input opKind_e kind, input alu_pkg::word_t a,
		input alu_pkg::word_t b);
		logic [7:0]     opc;
		alu_pkg::word_t p;
		opc = opcodeOf(kind, 4'(randBelow(16)));
		p   = randWord();
		@(negedge clk);
		compareOutputs();
		opValid  = valid;
		opcode   = opc;
		operandA = a;
		operandB = b;
		pc       = p;
		if (valid)
			predict(kind, opc, a, b, p);
		else
			expValid = 1'b0; // Everything else holds
	endtask

	task automatic endTest(input string name, input int ops, input int startErrors);
		issue(1'b0, kUndef, 16'h0000, 16'h0000); // Drain the last result
		tests++;
		$display("Test %s: %0d operations, %0d errors", name, ops, errors - startErrors);
	endtask

	task automatic runReset();
		int startErrors;
		startErrors = errors;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		compareOutputs(); // Still inside reset
		rstN = 1'b1;
		endTest("reset", 0, startErrors);
	endtask

	task automatic runGroup(input string name, input int ops, input opKind_e first, input int span);
		int             startErrors;
		opKind_e        kind;
		alu_pkg::word_t b;
		startErrors = errors;
		for (int i = 0; i < ops; i++)
		begin
			kind = opKind_e'(int'(first) + randBelow(span));
			b    = randWord();
			if ((kind == kLsh || kind == kAshu) && randBelow(2) == 0)
				b = alu_pkg::word_t'(randBelow(41) - 20); // Small counts, both signs
			issue(1'b1, kind, randWord(), b);
		end
		endTest(name, ops, startErrors);
	endtask

	task automatic runBranch();
		int             startErrors;
		opKind_e        kind;
		alu_pkg::word_t a;
		alu_pkg::word_t b;
		startErrors = errors;
		for (int i = 0; i < BranchPairs; i++)
		begin
			kind = (randBelow(2) != 0) ? kCmp : kCmpi;
			a    = randWord();
			b    = randWord();
			if (randBelow(4) == 0)
				a = (kind == kCmp) ? b : {{8{b[7]}}, b[7:0]}; // Equal operands for Z
			issue(1'b1, kind, a, b);
			a = {randWord() & 16'hFFF0} | 16'(randBelow(16)); // Condition code in the low nibble
			issue(1'b1, (randBelow(2) != 0) ? kBcond : kJcond, a, randWord());
		end
		endTest("branch", 2 * BranchPairs, startErrors);
	endtask

	task automatic runStream();
		int      startErrors;
		opKind_e kind;
		logic    valid;
		startErrors = errors;
		for (int i = 0; i < StreamOps; i++)
		begin
			valid = randBelow(4) != 0; // Roughly one gap in four
			kind  = (randBelow(2) == 0) ? kUndef : opKind_e'(randBelow(24));
			issue(valid, kind, randWord(), randWord());
		end
		endTest("stream", StreamOps, startErrors);
	endtask

	initial
	begin
		rstN      = 1'b0;
		opValid   = 1'b0;
		opcode    = 8'h00;
		operandA  = 16'h0000;
		operandB  = 16'h0000;
		pc        = 16'h0000;
		expValid  = 1'b0;
		expResult = 16'h0000;
		expTaken  = 1'b0;
		mFlags    = 5'b00000;
		runReset();
		runGroup("arithmetic", ArithOps, kAdd, 6);
		runGroup("logic", LogicOps, kAnd, 10);
		runGroup("shift", ShiftOps, kLsh, 4);
		runBranch();
		runStream();
		errors += u_dut.uChecker.assertFails;
		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, u_dut.uChecker.assertFails);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/aluTop_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module aluTop_checker
(
	input wire logic            clk,
	input wire logic            rstN,
	input wire logic            opValid,
	input wire logic            resultValid,
	input wire alu_pkg::word_t  result,
	input wire alu_pkg::flags_t flags,
	input wire logic            taken
);

	int assertFails = 0; // Summed into the testbench error count

	// One register stage between opValid and resultValid
	validFollows: assert property (@(posedge clk) disable iff (!rstN)
		resultValid == $past(opValid))
	else
	begin
		assertFails++;
		$error("resultValid did not follow opValid by one cycle");
	end

	resetValues: assert property (@(posedge clk)
		!rstN |-> (!resultValid && !taken && result == '0 && flags == '0))
	else
	begin
		assertFails++;
		$error("Outputs left their reset values while rstN was low");
	end

	// Flags only load on an accepted op, which also raises resultValid
	flagsHold: assert property (@(posedge clk) disable iff (!rstN)
		!resultValid |-> $stable(flags))
	else
	begin
		assertFails++;
		$error("Flags changed in a cycle without a result");
	end

endmodule

bind aluTop aluTop_checker uChecker
(
	.clk         (clk),
	.rstN        (rstN),
	.opValid     (opValid),
	.resultValid (resultValid),
	.result      (result),
	.flags       (flags),
	.taken       (taken)
);

`default_nettype wire

/* design/aluTop.sv */
`timescale 1ns/1ps
`default_nettype none

module aluTop
(
	input  wire logic            clk,
	input  wire logic            rstN,
	input  wire logic            opValid,
	input  wire logic [7:0]      opcode,
	input  wire alu_pkg::word_t  operandA,
	input  wire alu_pkg::word_t  operandB,
	input  wire alu_pkg::word_t  pc,
	output logic                 resultValid,
	output alu_pkg::word_t       result,
	output alu_pkg::flags_t      flags,
	output logic                 taken
);

	alu_pkg::opClass_e opClass;
	alu_pkg::word_t    opB;        // Extended second operand
	logic              shiftRight;
	alu_pkg::word_t    sum;
	alu_pkg::flags_t   arithFlags;
	alu_pkg::word_t    value;
	logic              zero;
	alu_pkg::word_t    target;
	logic              take;

	aluDecode uDecode
	(
		.opcode     (opcode),
		.operandB   (operandB),
		.opClass    (opClass),
		.opB        (opB),
		.shiftRight (shiftRight)
	);

	aluArith uArith
	(
		.opClass  (opClass),
		.operandA (operandA),
		.opB      (opB),
		.flagsIn  (flags), // Stored flags feed the unchanged bits
		.sum      (sum),
		.flagsOut (arithFlags)
	);

	aluLogicShift uLogicShift
	(
		.opClass    (opClass),
		.operandA   (operandA),
		.opB        (opB),
		.shiftRight (shiftRight),
		.value      (value),
		.zero       (zero)
	);

	branchUnit uBranch
	(
		.opClass  (opClass),
		.cond     (operandA[3:0]),
		.pc       (pc),
		.opB      (opB),
		.flagsNow (flags), // Conditions see flags before this op
		.target   (target),
		.take     (take)
	);

	aluWriteback uWriteback
	(
		.clk         (clk),
		.rstN        (rstN),
		.opValid     (opValid),
		.opClass     (opClass),
		.sum         (sum),
		.value       (value),
		.target      (target),
		.arithFlags  (arithFlags),
		.zero        (zero),
		.take        (take),
		.operandA    (operandA),
		.result      (result),
		.resultValid (resultValid),
		.taken       (taken),
		.flags       (flags)
	);

endmodule

`default_nettype wire

/* design/aluWriteback.sv */
`timescale 1ns/1ps
`default_nettype none

module aluWriteback
(
	input  wire logic              clk,
	input  wire logic              rstN,
	input  wire logic              opValid,
	input  wire alu_pkg::opClass_e opClass,
	input  wire alu_pkg::word_t    sum,
	input  wire alu_pkg::word_t    value,
	input  wire alu_pkg::word_t    target,
	input  wire alu_pkg::flags_t   arithFlags,
	input  wire logic              zero,
	input  wire logic              take,
	input  wire alu_pkg::word_t    operandA,
	output alu_pkg::word_t         result,
	output logic                   resultValid,
	output logic                   taken,
	output alu_pkg::flags_t        flags
);

	alu_pkg::word_t  nextResult;
	alu_pkg::flags_t nextFlags;

	always_comb
	begin
		nextResult = operandA; // Undecoded ops pass A
		nextFlags  = flags;
		case (opClass)
			alu_pkg::opAdd, alu_pkg::opAddU, alu_pkg::opSub, alu_pkg::opCmp:
			begin
				nextResult = sum;
				nextFlags  = arithFlags;
			end
			alu_pkg::opAnd, alu_pkg::opOr, alu_pkg::opXor, alu_pkg::opNot:
			begin
				nextResult  = value;
				nextFlags.z = zero; // Only Z moves for bitwise ops
			end
			alu_pkg::opMov, alu_pkg::opMovI, alu_pkg::opLui,
			alu_pkg::opShiftL, alu_pkg::opShiftA: nextResult = value;
			alu_pkg::opBranch, alu_pkg::opJump:   nextResult = target;
			default:                              nextResult = operandA;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			result      <= '0;
			resultValid <= 1'b0;
			taken       <= 1'b0;
			flags       <= '0;
		end
		else if (opValid)
		begin
			result      <= nextResult;
			resultValid <= 1'b1;
			taken       <= take;
			flags       <= nextFlags; // Visible with its result
		end
		else
			resultValid <= 1'b0; // Everything else holds
	end

endmodule

`default_nettype wire

/* design/branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module branchUnit
(
	input  wire alu_pkg::opClass_e opClass,
	input  wire logic [3:0]        cond,
	input  wire alu_pkg::word_t    pc,
	input  wire alu_pkg::word_t    opB,
	input  wire alu_pkg::flags_t   flagsNow,
	output alu_pkg::word_t         target,
	output logic                   take
);

	logic condMet;  // Condition true against stored flags
	logic isBranch;
	logic isJump;

	always_comb
	begin
		condMet = 1'b0;
		case (cond)
			`COND_EQ: condMet = flagsNow.z;
			`COND_NE: condMet = !flagsNow.z;
			`COND_GE: condMet = flagsNow.n || flagsNow.z;
			`COND_CS: condMet = flagsNow.c;
			`COND_CC: condMet = !flagsNow.c;
			`COND_HI: condMet = flagsNow.l;
			`COND_LS: condMet = !flagsNow.l;
			`COND_LO: condMet = !flagsNow.l && !flagsNow.z;
			`COND_HS: condMet = flagsNow.l || flagsNow.z;
			`COND_GT: condMet = flagsNow.n;
			`COND_LE: condMet = !flagsNow.n;
			`COND_FS: condMet = flagsNow.f;
			`COND_FC: condMet = !flagsNow.f;
			`COND_LT: condMet = !flagsNow.n && !flagsNow.z;
			`COND_UC: condMet = 1'b1;
			`COND_NJ: condMet = 1'b0;
			default:  condMet = 1'b0;
		endcase
	end

	assign isBranch = opClass == alu_pkg::opBranch;
	assign isJump   = opClass == alu_pkg::opJump;
	assign take     = (isBranch || isJump) && condMet; // Low for every other class

	always_comb
	begin
		if (!take)
			target = pc + 1'b1; // Fall through
		else if (isBranch)
			target = pc + opB;  // PC relative
		else
			target = opB;       // Absolute from register
	end

endmodule

`default_nettype wire

/* design/aluLogicShift.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module aluLogicShift
(
	input  wire alu_pkg::opClass_e opClass,
	input  wire alu_pkg::word_t    operandA,
	input  wire alu_pkg::word_t    opB,
	input  wire logic              shiftRight,
	output alu_pkg::word_t         value,
	output logic                   zero
);

	logic           overShift; // Amount of a full word or more
	logic [3:0]     amount;
	alu_pkg::word_t signFill;  // All copies of A's sign
	alu_pkg::word_t shlValue;
	alu_pkg::word_t shrValue;
	alu_pkg::word_t sraValue;

	assign overShift = |opB[`ALU_WIDTH-1:4];
	assign amount    = opB[3:0];
	assign signFill  = {`ALU_WIDTH{operandA[`ALU_WIDTH-1]}};
	assign shlValue  = overShift ? '0 : operandA << amount;
	assign shrValue  = overShift ? '0 : operandA >> amount;
	assign sraValue  = overShift ? signFill : alu_pkg::word_t'($signed(operandA) >>> amount);

	always_comb
	begin
		value = operandA;
		case (opClass)
			alu_pkg::opAnd:    value = operandA & opB;
			alu_pkg::opOr:     value = operandA | opB;
			alu_pkg::opXor:    value = operandA ^ opB;
			alu_pkg::opNot:    value = ~operandA;
			alu_pkg::opMov:    value = operandA;
			alu_pkg::opMovI:   value = opB;
			alu_pkg::opLui:    value = opB; // Decoder already placed the byte high
			alu_pkg::opShiftL: value = shiftRight ? shrValue : shlValue;
			alu_pkg::opShiftA: value = shiftRight ? sraValue : shlValue; // Left is the same as logical
			default:           value = operandA;
		endcase
	end

	assign zero = value == '0;

endmodule

`default_nettype wire

/* design/aluArith.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module aluArith
(
	input  wire alu_pkg::opClass_e opClass,
	input  wire alu_pkg::word_t    operandA,
	input  wire alu_pkg::word_t    opB,
	input  wire alu_pkg::flags_t   flagsIn,
	output alu_pkg::word_t         sum,
	output alu_pkg::flags_t        flagsOut
);

	localparam int Msb = `ALU_WIDTH - 1;

	logic [`ALU_WIDTH:0] addFull; // Carry in the top bit
	alu_pkg::word_t      diff;
	logic                addOvf;  // Same signs in, other sign out
	logic                subOvf;  // Different signs in, sign of A lost
	logic                below;   // Unsigned A < B
	logic                belowS;  // Signed A < B

	assign addFull = {1'b0, operandA} + {1'b0, opB};
	assign diff    = operandA - opB;
	assign addOvf  = (operandA[Msb] == opB[Msb]) && (addFull[Msb] != operandA[Msb]);
	assign subOvf  = (operandA[Msb] != opB[Msb]) && (diff[Msb] != operandA[Msb]);
	assign below   = operandA < opB;
	assign belowS  = $signed(operandA) < $signed(opB);

	always_comb
	begin
		flagsOut = flagsIn; // Untouched bits carry over
		sum      = diff;    // Compare also reports the difference
		case (opClass)
			alu_pkg::opAdd:
			begin
				sum        = addFull[Msb:0];
				flagsOut.c = addFull[`ALU_WIDTH];
				flagsOut.f = addOvf;
			end
			alu_pkg::opAddU:
			begin
				sum        = addFull[Msb:0];
				flagsOut.c = addFull[`ALU_WIDTH]; // F left as it was
			end
			alu_pkg::opSub:
			begin
				flagsOut.c = below; // Borrow
				flagsOut.f = subOvf;
			end
			alu_pkg::opCmp:
			begin
				flagsOut.l = below;   // Three independent results
				flagsOut.n = belowS;
				flagsOut.z = operandA == opB;
			end
			default: flagsOut = flagsIn;
		endcase
	end

endmodule

`default_nettype wire

/* design/aluDecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module aluDecode
(
	input  wire logic [7:0]       opcode,
	input  wire alu_pkg::word_t   operandB,
	output alu_pkg::opClass_e     opClass,
	output alu_pkg::word_t        opB,
	output logic                  shiftRight
);

	localparam int ExtWidth = `ALU_WIDTH - `ALU_IMM_WIDTH; // Bits added above the immediate

	alu_pkg::word_t immSigned; // Low byte, sign extended
	alu_pkg::word_t immZero;   // Low byte, zero extended
	alu_pkg::word_t immUpper;  // Low byte moved to the top
	alu_pkg::word_t magnitude; // Register shift amount

	assign immSigned = {{ExtWidth{operandB[`ALU_IMM_WIDTH-1]}}, operandB[`ALU_IMM_WIDTH-1:0]};
	assign immZero   = {{ExtWidth{1'b0}}, operandB[`ALU_IMM_WIDTH-1:0]};
	assign immUpper  = {operandB[`ALU_IMM_WIDTH-1:0], {ExtWidth{1'b0}}};
	assign magnitude = operandB[`ALU_WIDTH-1] ? (~operandB + 1'b1) : operandB; // Two's complement abs

	always_comb
	begin
		opClass    = alu_pkg::opNone;
		opB        = operandB;     // Register forms take operandB as is
		shiftRight = 1'b0;
		case (opcode) inside
			`OP_ADD:   opClass = alu_pkg::opAdd;
			`OP_ADDU:  opClass = alu_pkg::opAddU;
			`OP_SUB:   opClass = alu_pkg::opSub;
			`OP_CMP:   opClass = alu_pkg::opCmp;
			`OP_AND:   opClass = alu_pkg::opAnd;
			`OP_OR:    opClass = alu_pkg::opOr;
			`OP_XOR:   opClass = alu_pkg::opXor;
			`OP_NOT:   opClass = alu_pkg::opNot;
			`OP_MOV:   opClass = alu_pkg::opMov;
			`OP_JCOND: opClass = alu_pkg::opJump; // Target comes straight from operandB
			`OP_ADDI:
			begin
				opClass = alu_pkg::opAdd;
				opB     = immSigned;
			end
			`OP_SUBI:
			begin
				opClass = alu_pkg::opSub;
				opB     = immSigned;
			end
			`OP_CMPI:
			begin
				opClass = alu_pkg::opCmp;
				opB     = immSigned;
			end
			`OP_BCOND:
			begin
				opClass = alu_pkg::opBranch;
				opB     = immSigned; // Signed displacement from pc
			end
			`OP_ADDUI:
			begin
				opClass = alu_pkg::opAddU;
				opB     = immZero;
			end
			`OP_ANDI:
			begin
				opClass = alu_pkg::opAnd;
				opB     = immZero;
			end
			`OP_ORI:
			begin
				opClass = alu_pkg::opOr;
				opB     = immZero;
			end
			`OP_XORI:
			begin
				opClass = alu_pkg::opXor;
				opB     = immZero;
			end
			`OP_MOVI:
			begin
				opClass = alu_pkg::opMovI;
				opB     = immZero;
			end
			`OP_LUI:
			begin
				opClass = alu_pkg::opLui;
				opB     = immUpper;
			end
			`OP_LSH, `OP_ASHU:
			begin
				opClass    = (opcode == `OP_LSH) ? alu_pkg::opShiftL : alu_pkg::opShiftA;
				opB        = magnitude;
				shiftRight = operandB[`ALU_WIDTH-1]; // Negative amount shifts right
			end
			`OP_LSHI, `OP_ASHUI:
			begin
				opClass    = opcode[1] ? alu_pkg::opShiftA : alu_pkg::opShiftL; // Bit 1 splits LSHI/ASHUI
				opB        = alu_pkg::word_t'(operandB[3:0]);
				shiftRight = opcode[`OP_SHIFT_DIR_BIT];
			end
			default:   opClass = alu_pkg::opNone;
		endcase
	end

endmodule

`default_nettype wire

/* design/alu_pkg.sv */
`default_nettype none
`include "alu_consts.svh"

package alu_pkg;

	typedef logic [`ALU_WIDTH-1:0] word_t; // One data word

	// Operation class after decode, exactly sixteen entries
	typedef enum logic [3:0]
	{
		opAdd,    // ADD, ADDI
		opAddU,   // ADDU, ADDUI
		opSub,    // SUB, SUBI
		opCmp,    // CMP, CMPI
		opAnd,
		opOr,
		opXor,
		opNot,
		opMov,
		opMovI,
		opLui,
		opShiftL, // LSH, LSHI
		opShiftA, // ASHU, ASHUI
		opBranch, // Bcond
		opJump,   // Jcond
		opNone    // Undecoded, passes operandA
	} opClass_e;

	// Member order puts c at bit 0 and n at bit 4
	typedef struct packed
	{
		logic n; // Signed less than
		logic z; // Zero or equal
		logic l; // Unsigned less than
		logic f; // Signed overflow
		logic c; // Carry or borrow
	} flags_t;

endpackage

`default_nettype wire

/* include/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_WIDTH     16 // Data path width
`define ALU_IMM_WIDTH 8  // Immediate sits in the low byte of operandB

// Register forms, upper nibble zero
`define OP_AND   8'b00000001
`define OP_OR    8'b00000010
`define OP_XOR   8'b00000011
`define OP_ADD   8'b00000101
`define OP_ADDU  8'b00000110
`define OP_SUB   8'b00001001
`define OP_CMP   8'b00001011
`define OP_MOV   8'b00001101
`define OP_NOT   8'b00001111

// Immediate forms, low nibble is don't care
`define OP_ANDI  8'b0001????
`define OP_ORI   8'b0010????
`define OP_XORI  8'b0011????
`define OP_ADDI  8'b0101????
`define OP_ADDUI 8'b0110????
`define OP_SUBI  8'b1001????
`define OP_CMPI  8'b1011????
`define OP_MOVI  8'b1101????
`define OP_LUI   8'b1111????

// Shifts, bit 0 of the immediate forms picks the direction
`define OP_LSHI  8'b1000000?
`define OP_ASHUI 8'b1000001?
`define OP_LSH   8'b10000100
`define OP_ASHU  8'b10000110
`define OP_SHIFT_DIR_BIT 0 // Set means shift right

// Control transfer
`define OP_BCOND 8'b1100????
`define OP_JCOND 8'b01001100

// Condition codes in operandA[3:0]
`define COND_EQ 4'h0
`define COND_NE 4'h1
`define COND_CS 4'h2
`define COND_CC 4'h3
`define COND_HI 4'h4
`define COND_LS 4'h5
`define COND_GT 4'h6
`define COND_LE 4'h7
`define COND_FS 4'h8
`define COND_FC 4'h9
`define COND_LO 4'hA
`define COND_HS 4'hB
`define COND_LT 4'hC
`define COND_GE 4'hD
`define COND_UC 4'hE
`define COND_NJ 4'hF

// Bit positions inside the flag register
`define FLAG_C 0
`define FLAG_F 1
`define FLAG_L 2
`define FLAG_Z 3
`define FLAG_N 4

`endif
